/* project.f */
verilog/dispatchPkg.sv
verilog/operandResolver.sv
verilog/issueRouter.sv
verilog/dispatchTop.sv
test/dispatch_assertions.sv
test/dispatchTb.sv

/* Makefile */
# Verilator build and run of the dispatch stage testbench
VERILATOR ?= verilator
TOP       ?= dispatchTb
OBJ_DIR   ?= obj_dir
FILELIST  ?= project.f
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert
PASS_TEXT ?= Simulation PASSED

SOURCES := $(wildcard verilog/*.sv test/*.sv)
BIN     := $(OBJ_DIR)/$(TOP)

.PHONY: all run check clean

all: check

# Rebuilt only when a source or the file list changes
$(BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -o $(TOP) -f $(FILELIST)

run: $(BIN)
	./$(BIN) 2>&1 | tee $(LOG)
	@grep -q "$(PASS_TEXT)" $(LOG)

check: run
	@grep -q "$(PASS_TEXT)" $(LOG) && echo "check: pass message found in $(LOG)" || \
		(echo "check: pass message missing from $(LOG)"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* test/dispatchTb.sv */
module dispatchTb;

    import dispatchPkg::*;

    localparam int cmpWidth     = 160;
    localparam int issueTimeout = 10;

    logic         clk;
    logic         reset;
    logic         idValid;
    decodedInst_t inst;
    regRead_t     regRead1;
    regRead_t     regRead2;
    robRead_t     robRead1;
    robRead_t     robRead2;
    robQuery_t    robQuery1;
    robQuery_t    robQuery2;
    rsIssue_t     aluIssue;
    rsIssue_t     branchIssue;
    rsIssue_t     lsIssue;

    // Model outputs for the inputs now driven
    rsIssue_t     expAlu;
    rsIssue_t     expBranch;
    rsIssue_t     expLs;
    robQuery_t    expQuery1;
    robQuery_t    expQuery2;
    // Queries seen in the issue cycle
    robQuery_t    lastQuery1;
    robQuery_t    lastQuery2;

    int checkCount;
    int errorCount;
    int timeoutCount;
    int seedValue;

    dispatchTop UUT (
        .clk         (clk),
        .reset       (reset),
        .idValid     (idValid),
        .inst        (inst),
        .regRead1    (regRead1),
        .regRead2    (regRead2),
        .robQuery1   (robQuery1),
        .robQuery2   (robQuery2),
        .robRead1    (robRead1),
        .robRead2    (robRead2),
        .aluIssue    (aluIssue),
        .branchIssue (branchIssue),
        .lsIssue     (lsIssue)
    );

    always #10 clk = ~clk;

    task automatic checkValue(input logic [cmpWidth-1:0] actual,
                              input logic [cmpWidth-1:0] expected, input string what);
        checkCount++;
        if (actual !== expected) begin
            errorCount++;
            $display("Error at %0t: %s mismatch, expected %h, got %h",
                     $time, what, expected, actual);
        end
    endtask

    // Class 0 ALU, 1 branch, 2 load/store; load/store range wins
    function automatic int classOf(input dispOp_t op);
        if (op >= lsFirst && op <= lsLast) return 2;
        if (op >= branchFirst && op <= branchLast) return 1;
        return 0;
    endfunction

    // Regfile first, ROB second, else the producer tag
    function automatic operand_t modelOperand(input regRead_t r, input robRead_t b);
        if (r.ready) return {1'b1, r.data};
        if (b.ready) return {1'b1, b.data};
        return {1'b0, {(dataWidth-tagWidth){1'b0}}, r.tag};
    endfunction

    function automatic robQuery_t modelQuery(input regRead_t r);
        if (r.ready) return '0;
        return {1'b1, r.tag};
    endfunction

    task automatic computeExpected();
        rsIssue_t pkt;
        pkt = {1'b1, inst.op, inst.imm, inst.pc, inst.destTag,
               modelOperand(regRead1, robRead1), modelOperand(regRead2, robRead2)};
        expAlu    = '0;
        expBranch = '0;
        expLs     = '0;
        expQuery1 = '0;
        expQuery2 = '0;
        if (idValid) begin
            case (classOf(inst.op))
                0:       expAlu = pkt;
                1:       expBranch = pkt;
                default: expLs = pkt;
            endcase
            expQuery1 = modelQuery(regRead1);
            expQuery2 = modelQuery(regRead2);
        end
    endtask

    task automatic driveIdle();
        idValid  = 1'b0;
        inst     = '0;
        regRead1 = '0;
        regRead2 = '0;
        robRead1 = '0;
        robRead2 = '0;
    endtask

    task automatic checkQueries(input robQuery_t q1, input robQuery_t q2);
        checkValue(cmpWidth'(robQuery1), cmpWidth'(q1), "robQuery1");
        checkValue(cmpWidth'(robQuery2), cmpWidth'(q2), "robQuery2");
    endtask

    task automatic checkPorts(input rsIssue_t a, input rsIssue_t b, input rsIssue_t l);
        checkValue(cmpWidth'(aluIssue), cmpWidth'(a), "aluIssue");
        checkValue(cmpWidth'(branchIssue), cmpWidth'(b), "branchIssue");
        checkValue(cmpWidth'(lsIssue), cmpWidth'(l), "lsIssue");
    endtask

    // Bounded wait for any station enable
    task automatic waitForIssue(output int cycles);
        int count;
        count  = 0;
        cycles = 0;
        while (cycles == 0 && count < issueTimeout) begin
            @(negedge clk);
            count++;
            if (aluIssue.enable || branchIssue.enable || lsIssue.enable) cycles = count;
        end
        if (cycles == 0) begin
            timeoutCount++;
            $display("Timeout at %0t: no reservation station port enabled within %0d cycles",
                     $time, issueTimeout);
        end
    endtask

    // One instruction for one cycle, then idle until it issues
    task automatic issueOne(input decodedInst_t i, input regRead_t r1, input regRead_t r2,
                            input robRead_t b1, input robRead_t b2);
        int cycles;
        @(posedge clk);
        #1;
        idValid  = 1'b1;
        inst     = i;
        regRead1 = r1;
        regRead2 = r2;
        robRead1 = b1;
        robRead2 = b2;
        computeExpected();
        @(negedge clk);
        checkQueries(expQuery1, expQuery2);
        lastQuery1 = robQuery1;
        lastQuery2 = robQuery2;
        @(posedge clk);
        #1;
        driveIdle();
        waitForIssue(cycles);
        checkValue(cmpWidth'(cycles), cmpWidth'(1), "issue latency");
        checkPorts(expAlu, expBranch, expLs);
    endtask

    task automatic testIdle();
        int n;
        for (n = 0; n < 3; n++) begin
            @(negedge clk);
            checkPorts('0, '0, '0);
            checkQueries('0, '0);
        end
    endtask

    task automatic testAluReady();
        decodedInst_t i;
        regRead_t     r1;
        regRead_t     r2;
        robRead_t     b;
        i  = {ADD, 32'h0000_0123, 32'h0000_1000, 4'd7};
        r1 = {1'b1, 32'hdead_beef, 4'd2};
        r2 = {1'b1, 32'h1234_5678, 4'd3};
        // ROB also ready, regfile must still win
        b  = {1'b1, 32'hffff_0000};
        issueOne(i, r1, r2, b, b);
        checkValue(cmpWidth'(lastQuery1), cmpWidth'(0), "ALU robQuery1 quiet");
        checkValue(cmpWidth'(lastQuery2), cmpWidth'(0), "ALU robQuery2 quiet");
        checkValue(cmpWidth'(aluIssue.src1), cmpWidth'({1'b1, 32'hdead_beef}), "ALU src1");
        checkValue(cmpWidth'(aluIssue.src2), cmpWidth'({1'b1, 32'h1234_5678}), "ALU src2");
        checkValue(cmpWidth'(aluIssue.destTag), cmpWidth'(4'd7), "ALU destTag");
    endtask

    task automatic testBranchRob(input dispOp_t op);
        decodedInst_t i;
        i = {op, 32'hffff_fff0, 32'h0000_2040, 4'd11};
        issueOne(i, {1'b0, 32'h0, 4'd3}, {1'b0, 32'h0, 4'd9},
                 {1'b1, 32'haaaa_0001}, {1'b1, 32'h5555_0002});
        // Each operand looks up its own tag
        checkValue(cmpWidth'(lastQuery1), cmpWidth'({1'b1, 4'd3}), "branch robQuery1");
        checkValue(cmpWidth'(lastQuery2), cmpWidth'({1'b1, 4'd9}), "branch robQuery2");
        checkValue(cmpWidth'(branchIssue.src1), cmpWidth'({1'b1, 32'haaaa_0001}), "branch src1");
        checkValue(cmpWidth'(branchIssue.src2), cmpWidth'({1'b1, 32'h5555_0002}), "branch src2");
    endtask

    task automatic testLsPending(input dispOp_t op);
        decodedInst_t i;
        i = {op, 32'h0000_0010, 32'h0000_3000, 4'd1};
        issueOne(i, {1'b0, 32'h1111_1111, 4'd5}, {1'b0, 32'h2222_2222, 4'd12}, '0, '0);
        checkValue(cmpWidth'(lsIssue.src1.ready), cmpWidth'(0), "ls src1 ready");
        checkValue(cmpWidth'(lsIssue.src1.value.asTag.tag), cmpWidth'(5), "ls src1 tag");
        checkValue(cmpWidth'(lsIssue.src2.ready), cmpWidth'(0), "ls src2 ready");
        checkValue(cmpWidth'(lsIssue.src2.value.asTag.tag), cmpWidth'(12), "ls src2 tag");
        checkValue(cmpWidth'(lsIssue.src1.value.asTag.reserved), cmpWidth'(0), "ls reserved");
    endtask

    // New instruction every cycle, outputs lag inputs by one
    task automatic testBackToBack(input int count);
        rsIssue_t prevAlu;
        rsIssue_t prevBranch;
        rsIssue_t prevLs;
        int       issued;
        int       n;
        issued    = 0;
        expAlu    = '0;
        expBranch = '0;
        expLs     = '0;
        for (n = 0; n <= count; n++) begin
            @(posedge clk);
            #1;
            prevAlu    = expAlu;
            prevBranch = expBranch;
            prevLs     = expLs;
            if (n < count) begin
                idValid          = 1'b1;
                inst.op          = dispOp_t'(opWidth'($urandom_range(0, int'(lsLast))));
                inst.imm         = $urandom();
                inst.pc          = $urandom();
                inst.destTag     = tagWidth'($urandom());
                regRead1         = {1'($urandom()), 32'($urandom()), tagWidth'($urandom())};
                regRead2         = {1'($urandom()), 32'($urandom()), tagWidth'($urandom())};
                robRead1         = {1'($urandom()), 32'($urandom())};
                robRead2         = {1'($urandom()), 32'($urandom())};
            end else begin
                driveIdle();
            end
            computeExpected();
            @(negedge clk);
            checkQueries(expQuery1, expQuery2);
            checkPorts(prevAlu, prevBranch, prevLs);
            if (n > 0 && (aluIssue.enable || branchIssue.enable || lsIssue.enable)) issued++;
        end
        checkValue(cmpWidth'(issued), cmpWidth'(count), "back-to-back issue count");
    endtask

    initial begin
        checkCount   = 0;
        errorCount   = 0;
        timeoutCount = 0;
        seedValue    = $urandom(41881);
        clk          = 1'b0;
        reset        = 1'b1;
        lastQuery1   = '0;
        lastQuery2   = '0;
        driveIdle();
        // Valid ALU instruction under reset never reaches a port
        idValid      = 1'b1;
        inst.op      = ADD;
        inst.destTag = 4'd6;
        repeat (2) @(posedge clk);
        #1;
        reset = 1'b0;
        driveIdle();

        testIdle();
        testAluReady();
        testBranchRob(BEQ);
        testBranchRob(JALR);
        testLsPending(LB);
        testLsPending(SW);
        testBackToBack(24);
        testIdle();

        $display("Checks: %0d  Errors: %0d  Timeouts: %0d", checkCount, errorCount, timeoutCount);
        if (errorCount == 0 && timeoutCount == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

/* test/dispatch_assertions.sv */
module dispatchAssertions (
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    idValid,
    input  dispatchPkg::robQuery_t  robQuery1,
    input  dispatchPkg::robQuery_t  robQuery2,
    input  dispatchPkg::rsIssue_t   aluIssue,
    input  dispatchPkg::rsIssue_t   branchIssue,
    input  dispatchPkg::rsIssue_t   lsIssue
);

    import dispatchPkg::*;

    // At most one station gets the instruction
    oneStation: assert property (@(posedge clk) disable iff (reset)
        $onehot0({aluIssue.enable, branchIssue.enable, lsIssue.enable}))
        else $error("more than one issue port enabled");

    // Unselected ports are null filled
    aluNull: assert property (@(posedge clk) disable iff (reset)
        !aluIssue.enable |-> (aluIssue == '0))
        else $error("ALU port not zero while disabled");
    branchNull: assert property (@(posedge clk) disable iff (reset)
        !branchIssue.enable |-> (branchIssue == '0))
        else $error("branch port not zero while disabled");
    lsNull: assert property (@(posedge clk) disable iff (reset)
        !lsIssue.enable |-> (lsIssue == '0))
        else $error("load/store port not zero while disabled");

    // ROB lookups only for a valid instruction
    query1Valid: assert property (@(posedge clk) disable iff (reset)
        robQuery1.enable |-> idValid)
        else $error("ROB query 1 without idValid");
    query2Valid: assert property (@(posedge clk) disable iff (reset)
        robQuery2.enable |-> idValid)
        else $error("ROB query 2 without idValid");

endmodule

bind dispatchTop dispatchAssertions checks (
    .clk         (clk),
    .reset       (reset),
    .idValid     (idValid),
    .robQuery1   (robQuery1),
    .robQuery2   (robQuery2),
    .aluIssue    (aluIssue),
    .branchIssue (branchIssue),
    .lsIssue     (lsIssue)
);

/* verilog/dispatchTop.sv */
module dispatchTop (
    input  logic                        clk,
    input  logic                        reset,

    // From decode
    input  logic                        idValid,
    input  dispatchPkg::decodedInst_t   inst,

    // From register file
    input  dispatchPkg::regRead_t       regRead1,
    input  dispatchPkg::regRead_t       regRead2,

    // ROB lookups, answered in the same cycle
    output dispatchPkg::robQuery_t      robQuery1,
    output dispatchPkg::robQuery_t      robQuery2,
    input  dispatchPkg::robRead_t       robRead1,
    input  dispatchPkg::robRead_t       robRead2,

    // Reservation-station ports
    output dispatchPkg::rsIssue_t       aluIssue,
    output dispatchPkg::rsIssue_t       branchIssue,
    output dispatchPkg::rsIssue_t       lsIssue
);

    import dispatchPkg::*;

    // Resolved operands into the router
    operand_t src1;
    operand_t src2;

    // Source operand 1
    operandResolver resolve1 (
        .idValid  (idValid),
        .regRead  (regRead1),
        .robQuery (robQuery1),
        .robRead  (robRead1),
        .operand  (src1)
    );

    // Source operand 2, own tag
    operandResolver resolve2 (
        .idValid  (idValid),
        .regRead  (regRead2),
        .robQuery (robQuery2),
        .robRead  (robRead2),
        .operand  (src2)
    );

    // Classify and register onto one port
    issueRouter router (
        .clk         (clk),
        .reset       (reset),
        .idValid     (idValid),
        .inst        (inst),
        .src1        (src1),
        .src2        (src2),
        .aluIssue    (aluIssue),
        .branchIssue (branchIssue),
        .lsIssue     (lsIssue)
    );

endmodule

/* verilog/issueRouter.sv */
module issueRouter (
    input  logic                        clk,
    input  logic                        reset,
    input  logic                        idValid,
    input  dispatchPkg::decodedInst_t   inst,
    input  dispatchPkg::operand_t       src1,
    input  dispatchPkg::operand_t       src2,
    output dispatchPkg::rsIssue_t       aluIssue,
    output dispatchPkg::rsIssue_t       branchIssue,
    output dispatchPkg::rsIssue_t       lsIssue
);

    import dispatchPkg::*;

    // Opcode class flags
    logic toBranch;
    logic toLs;

    // Packet shared by whichever station gets it
    rsIssue_t packet;

    // Next values of the three ports
    rsIssue_t aluNext;
    rsIssue_t branchNext;
    rsIssue_t lsNext;

    // Range compares on the ordered opcode
    assign toLs     = (inst.op >= lsFirst) && (inst.op <= lsLast);
    assign toBranch = (inst.op >= branchFirst) && (inst.op <= branchLast);

    // Build the issue packet
    always_comb begin
        packet         = '0;
        packet.enable  = 1'b1;
        packet.op      = inst.op;
        packet.imm     = inst.imm;
        packet.pc      = inst.pc;
        packet.destTag = inst.destTag;
        // Operands already resolved upstream
        packet.src1    = src1;
        packet.src2    = src2;
    end

    // Steer to exactly one station
    // unselected ports stay null
    always_comb begin
        aluNext    = '0;
        branchNext = '0;
        lsNext     = '0;
        if (idValid) begin
            if (toLs) begin
                // Load/store checked first
                lsNext = packet;
            end else if (toBranch) begin
                branchNext = packet;
            end else begin
                // Everything else, NOP included
                aluNext = packet;
            end
        end
    end

    // Output register, one cycle latency
    always_ff @(posedge clk) begin
        if (reset) begin
            // All ports null out of reset
            aluIssue    <= '0;
            branchIssue <= '0;
            lsIssue     <= '0;
        end else begin
            aluIssue    <= aluNext;
            branchIssue <= branchNext;
            lsIssue     <= lsNext;
        end
    end

endmodule

/* verilog/operandResolver.sv */
module operandResolver (
    input  logic                    idValid,
    input  dispatchPkg::regRead_t   regRead,
    output dispatchPkg::robQuery_t  robQuery,
    input  dispatchPkg::robRead_t   robRead,
    output dispatchPkg::operand_t   operand
);

    import dispatchPkg::*;

    // Resolved word before the ready bit joins it
    operandValue_u resolved;
    logic          resolvedReady;

    // Priority: register file, then ROB, then the tag
    always_comb begin
        robQuery      = '0;
        resolved      = '0;
        resolvedReady = 1'b0;
        if (idValid) begin
            if (regRead.ready) begin
                // Value already committed
                resolved.asData = regRead.data;
                resolvedReady   = 1'b1;
            end else begin
                // Ask the ROB with this operand's own tag
                robQuery.enable = 1'b1;
                robQuery.tag    = regRead.tag;
                if (robRead.ready) begin
                    // Result written back but not committed yet
                    resolved.asData = robRead.data;
                    resolvedReady   = 1'b1;
                end else begin
                    // Still in flight
                    // station waits on this tag
                    resolved.asTag.tag = regRead.tag;
                end
            end
        end
    end

    // Ready bit in front of the value
    assign operand.ready = resolvedReady;
    assign operand.value = resolved;

endmodule

/* verilog/dispatchPkg.sv */
package dispatchPkg;

    // Datapath widths
    localparam int dataWidth = 32;
    localparam int addrWidth = 32;
    localparam int tagWidth  = 4;
    localparam int opWidth   = 6;

    // Internal opcodes, each class kept contiguous
    // ALU class first, NOP at code 0
    typedef enum logic [opWidth-1:0] {
        NOP, LUI, AUIPC,
        ADDI, SLTI, SLTIU, XORI, ORI, ANDI, SLLI, SRLI, SRAI,
        ADD, SUB, SLL, SLT, SLTU, XOR, SRL, SRA, OR, AND,
        // Branch class, jumps included
        BEQ, BNE, BLT, BGE, BLTU, BGEU, JAL, JALR,
        // Load/store class
        LB, LH, LW, LBU, LHU, SB, SH, SW
    } dispOp_t;

    // Class range edges
    localparam dispOp_t branchFirst = BEQ;
    localparam dispOp_t branchLast  = JALR;
    localparam dispOp_t lsFirst     = LB;
    localparam dispOp_t lsLast      = SW;

    // Instruction from decode
    typedef struct packed {
        dispOp_t                op;
        logic [dataWidth-1:0]   imm;
        logic [addrWidth-1:0]   pc;
        logic [tagWidth-1:0]    destTag;
    } decodedInst_t;

    // Register file answer for one source
    typedef struct packed {
        logic                   ready;
        logic [dataWidth-1:0]   data;
        logic [tagWidth-1:0]    tag;
    } regRead_t;

    // Lookup request into the ROB
    typedef struct packed {
        logic                   enable;
        logic [tagWidth-1:0]    tag;
    } robQuery_t;

    // ROB answer, same cycle
    typedef struct packed {
        logic                   ready;
        logic [dataWidth-1:0]   data;
    } robRead_t;

    // Producer tag view of the operand word
    typedef struct packed {
        logic [dataWidth-tagWidth-1:0] reserved;
        logic [tagWidth-1:0]           tag;
    } operandTag_t;

    // Operand word holds data or the tag that will produce it
    typedef union packed {
        logic [dataWidth-1:0]   asData;
        operandTag_t            asTag;
    } operandValue_u;

    // Ready set means value is data
    typedef struct packed {
        logic                   ready;
        operandValue_u          value;
    } operand_t;

    // One reservation-station port
    typedef struct packed {
        logic                   enable;
        dispOp_t                op;
        logic [dataWidth-1:0]   imm;
        logic [addrWidth-1:0]   pc;
        logic [tagWidth-1:0]    destTag;
        operand_t               src1;
        operand_t               src2;
    } rsIssue_t;

endpackage
